// ==== verilog/fetch_pkg.sv ====
/*
 * fetch stage package
 * address and instruction types, redirect and exception encodings,
 * exception vector offsets and the aligner state encoding
 */
package fetch_pkg;

  // byte address and one instruction memory word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  // one 16-bit instruction parcel
  typedef logic [15:0] half_t;

  // where the next fetch address comes from on a redirect
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_src_e;

  // exception kind, picks the vector slot
  typedef enum logic [1:0] {
    EXC_RST     = 2'd0,
    EXC_ILLINSN = 2'd1,
    EXC_IRQ     = 2'd2,
    EXC_IRQ_NM  = 2'd3
  } exc_cause_e;

  // byte offsets inside the vector block
  localparam addr_t EXC_OFF_RST     = 32'h0000_0000;
  localparam addr_t EXC_OFF_ILLINSN = 32'h0000_0004;
  localparam addr_t EXC_OFF_IRQ     = 32'h0000_0008;
  localparam addr_t EXC_OFF_IRQ_NM  = 32'h0000_000C;

  // half-word offset machine of the aligner, IDLE is the reset state
  typedef enum logic [3:0] {
    IDLE, WAIT_ALIGNED, VALID_ALIGNED, UNALIGNED_16,
    WAIT_UNALIGNED_32, VALID_UNALIGNED_32,
    WAIT_JUMPED_ALIGNED, VALID_JUMPED_ALIGNED,
    WAIT_JUMPED_UNALIGNED, VALID_JUMPED_UNALIGNED
  } align_state_e;

endpackage

// ==== verilog/fetch_if.sv ====
/*
 * fetch bus between the aligner and the memory port
 * one word request at a time, the port answers with valid and holds the word
 */
interface fetch_if;

  // request strobe from the aligner
  logic             req;
  // word address of the request, driven by the next-address mux
  fetch_pkg::addr_t addr;
  // last word returned and its address, held until the next valid
  fetch_pkg::word_t rdata;
  logic             valid;
  fetch_pkg::addr_t last_addr;

  // requesting side
  modport align (output req, input rdata, valid, last_addr);

  // serving side
  modport port (input req, addr, output rdata, valid, last_addr);

endinterface

// ==== verilog/pc_select.sv ====
/*
 * next fetch address mux
 * builds the exception vector from the boot address and picks the
 * redirect target or the sequential word address
 */
module pc_select #(
  parameter int EXC_VEC_BITS = 5
) (
  input  fetch_pkg::addr_t      boot_addr_i,
  input  fetch_pkg::pc_src_e    pc_src_i,
  input  fetch_pkg::addr_t      jump_target_i,
  input  fetch_pkg::addr_t      epc_i,
  input  fetch_pkg::exc_cause_e exc_cause_i,
  input  fetch_pkg::addr_t      last_addr_i,
  input  logic                  incr_i,
  output fetch_pkg::addr_t      next_addr_o,
  output logic                  target_unaligned_o
);

  // low boot address bits replaced by the vector offset
  localparam fetch_pkg::addr_t VEC_MASK = (32'h1 << EXC_VEC_BITS) - 32'h1;

  fetch_pkg::addr_t exc_off;
  fetch_pkg::addr_t exc_vec;
  fetch_pkg::addr_t boot_vec;
  fetch_pkg::addr_t target;

  // vector slot per cause
  always_comb begin
    case (exc_cause_i)
      fetch_pkg::EXC_ILLINSN: exc_off = fetch_pkg::EXC_OFF_ILLINSN;
      fetch_pkg::EXC_IRQ:     exc_off = fetch_pkg::EXC_OFF_IRQ;
      fetch_pkg::EXC_IRQ_NM:  exc_off = fetch_pkg::EXC_OFF_IRQ_NM;
      default:                exc_off = fetch_pkg::EXC_OFF_RST;
    endcase
  end

  // upper boot bits kept, offset dropped into the low bits
  assign exc_vec  = (boot_addr_i & ~VEC_MASK) | (exc_off & VEC_MASK);
  assign boot_vec = (boot_addr_i & ~VEC_MASK) | (fetch_pkg::EXC_OFF_RST & VEC_MASK);

  // redirect target, may sit on a half-word
  always_comb begin
    case (pc_src_i)
      fetch_pkg::PC_JUMP: target = jump_target_i;
      fetch_pkg::PC_EXC:  target = exc_vec;
      fetch_pkg::PC_ERET: target = epc_i;
      default:            target = boot_vec;
    endcase
  end

  // memory only sees word addresses
  assign next_addr_o        = incr_i ? last_addr_i + 32'd4 : {target[31:2], 2'b00};
  // aligner starts from the upper half of the first word
  assign target_unaligned_o = target[1];

endmodule

// ==== verilog/instr_mem_port.sv ====
/*
 * instruction memory port
 * runs the req/gnt/rvalid protocol with one request in flight, drops
 * responses of abandoned requests and holds the last word for the aligner
 */
module instr_mem_port (
  input  logic             clk,
  input  logic             rst_n,
  fetch_if.port            fetch,
  output logic             instr_req_o,
  output fetch_pkg::addr_t instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  fetch_pkg::word_t instr_rdata_i
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT_GNT,
    PORT_WAIT_RVALID
  } port_state_e;

  port_state_e      state_q, state_d;
  // in-flight request was overtaken by a newer one
  logic             stale_q, stale_d;
  logic             valid;
  logic             issue;
  fetch_pkg::addr_t issue_addr;
  fetch_pkg::addr_t bus_addr_q;
  fetch_pkg::addr_t want_addr_q;
  fetch_pkg::word_t rdata_q;
  fetch_pkg::addr_t last_addr_q;

  ////////////////////////////////////////////////////////////
  // protocol FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    stale_d      = stale_q;
    valid        = 1'b0;
    issue        = 1'b0;
    issue_addr   = fetch.addr;
    instr_req_o  = 1'b0;
    instr_addr_o = bus_addr_q;

    case (state_q)
      PORT_IDLE: begin
        issue = fetch.req;
      end

      PORT_WAIT_GNT: begin
        // address stays on the bus until granted
        instr_req_o = 1'b1;
        if (fetch.req) begin
          stale_d = 1'b1;
        end
        if (instr_gnt_i) begin
          state_d = PORT_WAIT_RVALID;
        end
      end

      PORT_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          if (stale_q) begin
            // swallow the old word, send the newest address instead
            issue = 1'b1;
            if (!fetch.req) begin
              issue_addr = want_addr_q;
            end
          end else begin
            valid = 1'b1;
            // aligner may ask for the next word in the same cycle
            issue = fetch.req;
            if (!fetch.req) begin
              state_d = PORT_IDLE;
            end
          end
        end else if (fetch.req) begin
          stale_d = 1'b1;
        end
      end

      default: begin
        state_d = PORT_IDLE;
      end
    endcase

    // put a fresh request straight on the bus
    if (issue) begin
      instr_req_o  = 1'b1;
      instr_addr_o = issue_addr;
      stale_d      = 1'b0;
      state_d      = instr_gnt_i ? PORT_WAIT_RVALID : PORT_WAIT_GNT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PORT_IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // address and data holding
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (issue) begin
      bus_addr_q <= issue_addr;
    end
    // newest address the aligner asked for
    if (fetch.req) begin
      want_addr_q <= fetch.addr;
    end
    if (valid) begin
      rdata_q     <= instr_rdata_i;
      last_addr_q <= bus_addr_q;
    end
  end

  // response cycle bypasses the holding registers
  assign fetch.valid     = valid;
  assign fetch.rdata     = valid ? instr_rdata_i : rdata_q;
  assign fetch.last_addr = valid ? bus_addr_q : last_addr_q;

endmodule

// ==== verilog/if_align.sv ====
/*
 * instruction aligner
 * offset FSM that cuts 16-bit and 32-bit instructions out of fetched words,
 * joins word-crossing instructions, and the IF/ID registers
 */
module if_align (
  input  logic             clk,
  input  logic             rst_n,
  fetch_if.align           fetch,
  input  logic             redirect_i,
  input  logic             target_unaligned_i,
  input  logic             take_i,
  output logic             incr_o,
  output logic             valid_o,
  output fetch_pkg::word_t instr_o,
  output fetch_pkg::addr_t pc_o,
  output fetch_pkg::word_t instr_id_o,
  output fetch_pkg::addr_t pc_id_o
);

  fetch_pkg::align_state_e state_q, state_d;

  // parcel kind of the lower and upper half of the current word
  logic             is_comp_lo;
  logic             is_comp_hi;
  logic             unaligned;
  logic             crossword;
  logic             fetch_req;
  logic             issue;
  logic             jumped;
  logic             held;
  // lower half of a crossing instruction and the word it came from
  fetch_pkg::half_t half_q;
  fetch_pkg::addr_t half_addr_q;

  assign is_comp_lo = fetch.rdata[1:0] != 2'b11;
  assign is_comp_hi = fetch.rdata[17:16] != 2'b11;

  // decode takes the instruction shown this cycle
  assign issue = valid_o & take_i;

  // sequential word unless flow changes
  assign incr_o    = ~redirect_i;
  assign fetch.req = fetch_req;

  // aligned states differ only in how they were entered
  assign jumped = (state_q == fetch_pkg::WAIT_JUMPED_ALIGNED) ||
                  (state_q == fetch_pkg::VALID_JUMPED_ALIGNED);
  assign held   = (state_q == fetch_pkg::VALID_ALIGNED) ||
                  (state_q == fetch_pkg::VALID_JUMPED_ALIGNED);

  ////////////////////////////////////////////////////////////
  // offset FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    fetch_req = 1'b0;
    valid_o   = 1'b0;
    unaligned = 1'b0;
    crossword = 1'b0;

    case (state_q)
      // nothing to show until the first redirect
      fetch_pkg::IDLE: begin
        state_d = fetch_pkg::IDLE;
      end

      // instruction starts at bit 0 of the word
      fetch_pkg::WAIT_ALIGNED, fetch_pkg::VALID_ALIGNED,
      fetch_pkg::WAIT_JUMPED_ALIGNED, fetch_pkg::VALID_JUMPED_ALIGNED: begin
        if (fetch.valid || held) begin
          valid_o = 1'b1;
          state_d = jumped ? fetch_pkg::VALID_JUMPED_ALIGNED : fetch_pkg::VALID_ALIGNED;
          if (take_i) begin
            if (!is_comp_lo) begin
              // full word used, next one is aligned
              fetch_req = 1'b1;
              state_d   = fetch_pkg::WAIT_ALIGNED;
            end else if (is_comp_hi) begin
              // upper half already here
              state_d = fetch_pkg::UNALIGNED_16;
            end else begin
              // upper half starts a crossing instruction
              fetch_req = 1'b1;
              state_d   = fetch_pkg::WAIT_UNALIGNED_32;
            end
          end
        end
      end

      // compressed instruction in the upper half, no fetch needed
      fetch_pkg::UNALIGNED_16: begin
        unaligned = 1'b1;
        valid_o   = 1'b1;
        if (take_i) begin
          fetch_req = 1'b1;
          state_d   = fetch_pkg::WAIT_ALIGNED;
        end
      end

      // 32-bit instruction split over two words
      fetch_pkg::WAIT_UNALIGNED_32, fetch_pkg::VALID_UNALIGNED_32: begin
        unaligned = 1'b1;
        crossword = 1'b1;
        if (fetch.valid || state_q == fetch_pkg::VALID_UNALIGNED_32) begin
          valid_o = 1'b1;
          state_d = fetch_pkg::VALID_UNALIGNED_32;
          if (take_i) begin
            if (is_comp_hi) begin
              state_d = fetch_pkg::UNALIGNED_16;
            end else begin
              fetch_req = 1'b1;
              state_d   = fetch_pkg::WAIT_UNALIGNED_32;
            end
          end
        end
      end

      // redirect landed on the upper half
      fetch_pkg::WAIT_JUMPED_UNALIGNED, fetch_pkg::VALID_JUMPED_UNALIGNED: begin
        unaligned = 1'b1;
        if (fetch.valid || state_q == fetch_pkg::VALID_JUMPED_UNALIGNED) begin
          state_d = fetch_pkg::VALID_JUMPED_UNALIGNED;
          if (is_comp_hi) begin
            valid_o = 1'b1;
            if (take_i) begin
              fetch_req = 1'b1;
              state_d   = fetch_pkg::WAIT_ALIGNED;
            end
          end else begin
            // upper half still missing, fetch it regardless of take
            fetch_req = 1'b1;
            state_d   = fetch_pkg::WAIT_UNALIGNED_32;
          end
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase

    // flow change wins over everything above
    if (redirect_i) begin
      fetch_req = 1'b1;
      state_d   = target_unaligned_i ? fetch_pkg::WAIT_JUMPED_UNALIGNED :
                                       fetch_pkg::WAIT_JUMPED_ALIGNED;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction and PC shown to decode
  ////////////////////////////////////////////////////////////

  // keep the upper half of the word we are leaving
  always_ff @(posedge clk) begin
    if (fetch_req) begin
      half_q      <= fetch.rdata[31:16];
      half_addr_q <= fetch.last_addr;
    end
  end

  always_comb begin
    instr_o = fetch.rdata;
    pc_o    = {fetch.last_addr[31:2], 2'b00};
    if (crossword) begin
      // new lower half on top, saved half below
      instr_o = {fetch.rdata[15:0], half_q};
      pc_o    = {half_addr_q[31:2], 2'b10};
    end else if (unaligned) begin
      instr_o = {2{fetch.rdata[31:16]}};
      pc_o    = {fetch.last_addr[31:2], 2'b10};
    end else if (is_comp_lo) begin
      instr_o = {2{fetch.rdata[15:0]}};
    end
  end

  // IF/ID registers, load only on an issue
  always_ff @(posedge clk) begin
    if (issue) begin
      instr_id_o <= instr_o;
      pc_id_o    <= pc_o;
    end
  end

endmodule

// ==== verilog/fetch_top.sv ====
/*
 * instruction fetch stage top level
 * next-address mux, memory port and aligner around one fetch bus
 */
module fetch_top #(
  parameter int EXC_VEC_BITS = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::addr_t      boot_addr_i,
  // flow change strobe and its qualifiers
  input  logic                  redirect_i,
  input  fetch_pkg::pc_src_e    pc_src_i,
  input  fetch_pkg::addr_t      jump_target_i,
  input  fetch_pkg::addr_t      epc_i,
  input  fetch_pkg::exc_cause_e exc_cause_i,
  input  logic                  take_i,
  // instruction memory
  output logic                  instr_req_o,
  output fetch_pkg::addr_t      instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  fetch_pkg::word_t      instr_rdata_i,
  // current instruction and the IF/ID copy
  output logic                  valid_o,
  output fetch_pkg::word_t      instr_o,
  output fetch_pkg::addr_t      pc_o,
  output fetch_pkg::word_t      instr_id_o,
  output fetch_pkg::addr_t      pc_id_o
);

  logic incr;
  logic target_unaligned;

  fetch_if fetch_bus ();

  pc_select #(
    .EXC_VEC_BITS(EXC_VEC_BITS)
  ) u_pc_select (
    .boot_addr_i       (boot_addr_i),
    .pc_src_i          (pc_src_i),
    .jump_target_i     (jump_target_i),
    .epc_i             (epc_i),
    .exc_cause_i       (exc_cause_i),
    .last_addr_i       (fetch_bus.last_addr),
    .incr_i            (incr),
    .next_addr_o       (fetch_bus.addr),
    .target_unaligned_o(target_unaligned)
  );

  instr_mem_port u_instr_mem_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch         (fetch_bus.port),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i)
  );

  if_align u_if_align (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch             (fetch_bus.align),
    .redirect_i        (redirect_i),
    .target_unaligned_i(target_unaligned),
    .take_i            (take_i),
    .incr_o            (incr),
    .valid_o           (valid_o),
    .instr_o           (instr_o),
    .pc_o              (pc_o),
    .instr_id_o        (instr_id_o),
    .pc_id_o           (pc_id_o)
  );

endmodule

// ==== verif/fetch_sva.sv ====
/*
 * memory protocol assertions, bound to the instruction memory port
 */
module fetch_sva (
  input logic             clk,
  input logic             rst_n,
  input logic             req_i,
  input fetch_pkg::addr_t addr_i,
  input logic             gnt_i,
  input logic             rvalid_i,
  input logic             valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // granted requests still waiting for their response, seen from the bus
  logic [1:0] in_flight_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight_q <= 2'd0;
    end else begin
      in_flight_q <= in_flight_q + {1'b0, req_i & gnt_i} - {1'b0, rvalid_i};
    end
  end

  // request and its address held until granted
  req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else $error("memory request dropped or address changed before grant");

  // response only while a granted request is in flight
  valid_outstanding_a: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i |-> rvalid_i && in_flight_q != 2'd0)
    else $error("fetch valid without an outstanding request");

  // quiet bus in reset
  reset_quiet_a: assert property (@(posedge clk) !rst_n |-> !req_i)
    else $error("memory request during reset");

endmodule

bind instr_mem_port fetch_sva sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_i   (instr_req_o),
  .addr_i  (instr_addr_o),
  .gnt_i   (instr_gnt_i),
  .rvalid_i(instr_rvalid_i),
  .valid_i (valid)
);

// ==== verif/fetch_checker.sv ====
/*
 * fetch stream checker
 * predicts each issued instruction and PC by walking the memory image
 * from the redirect target, and checks the IF/ID copy
 */
module fetch_checker #(
  parameter int EXC_VEC_BITS = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::word_t      mem_i [256],
  input  fetch_pkg::addr_t      boot_addr_i,
  input  logic                  redirect_i,
  input  fetch_pkg::pc_src_e    pc_src_i,
  input  fetch_pkg::addr_t      jump_target_i,
  input  fetch_pkg::addr_t      epc_i,
  input  fetch_pkg::exc_cause_e exc_cause_i,
  input  int                    count_i,
  input  logic                  valid_i,
  input  logic                  take_i,
  input  fetch_pkg::word_t      instr_i,
  input  fetch_pkg::addr_t      pc_i,
  input  fetch_pkg::word_t      instr_id_i,
  input  fetch_pkg::addr_t      pc_id_i,
  output logic                  done_o,
  output int                    errors_o,
  output int                    failed_o,
  output int                    tests_o
);
  timeunit 1ns;
  timeprecision 100ps;

  fetch_pkg::addr_t exp_pc;
  fetch_pkg::word_t last_instr;
  fetch_pkg::addr_t last_pc;
  logic             have_last;
  logic             started;
  logic             active;
  int               collected;
  int               test_err;

  // where the stream must start after a redirect
  function automatic fetch_pkg::addr_t start_pc();
    fetch_pkg::addr_t mask;
    fetch_pkg::addr_t off;
    mask = {32{1'b1}} >> (32 - EXC_VEC_BITS);
    case (exc_cause_i)
      fetch_pkg::EXC_ILLINSN: off = fetch_pkg::EXC_OFF_ILLINSN;
      fetch_pkg::EXC_IRQ:     off = fetch_pkg::EXC_OFF_IRQ;
      fetch_pkg::EXC_IRQ_NM:  off = fetch_pkg::EXC_OFF_IRQ_NM;
      default:                off = fetch_pkg::EXC_OFF_RST;
    endcase
    case (pc_src_i)
      fetch_pkg::PC_JUMP: start_pc = jump_target_i;
      fetch_pkg::PC_ERET: start_pc = epc_i;
      fetch_pkg::PC_EXC:  start_pc = (boot_addr_i & ~mask) | (off & mask);
      default:            start_pc = boot_addr_i & ~mask;
    endcase
  endfunction

  function automatic fetch_pkg::half_t half_at(input fetch_pkg::addr_t a);
    fetch_pkg::word_t w;
    w = mem_i[a[9:2]];
    half_at = a[1] ? w[31:16] : w[15:0];
  endfunction

  initial begin
    done_o    = 1'b0;
    errors_o  = 0;
    failed_o  = 0;
    tests_o   = 0;
    have_last = 1'b0;
    started   = 1'b0;
    active    = 1'b0;
    collected = 0;
    test_err  = 0;
    exp_pc    = '0;
  end

  // sampled mid-cycle, values equal those at the next rising edge
  always @(negedge clk) begin
    fetch_pkg::half_t h;
    fetch_pkg::word_t exp_instr;
    if (rst_n) begin
      // IF/ID must hold the last issued pair
      if (have_last && (instr_id_i !== last_instr || pc_id_i !== last_pc)) begin
        $display("ERR %0t: IF/ID holds %h at %h, expected %h at %h",
                 $time, instr_id_i, pc_id_i, last_instr, last_pc);
        errors_o++;
        test_err++;
      end

      // every issue is predicted, also past the count of the test
      if (started && valid_i && take_i) begin
        h = half_at(exp_pc);
        if (h[1:0] != 2'b11) begin
          exp_instr = {h, h};
        end else begin
          exp_instr = {half_at(exp_pc + 32'd2), h};
        end
        if (instr_i !== exp_instr || pc_i !== exp_pc) begin
          $display("ERR %0t: issued %h at %h, expected %h at %h",
                   $time, instr_i, pc_i, exp_instr, exp_pc);
          errors_o++;
          test_err++;
        end
        have_last  = 1'b1;
        last_instr = exp_instr;
        last_pc    = exp_pc;
        exp_pc     = exp_pc + ((h[1:0] != 2'b11) ? 32'd2 : 32'd4);
        if (active) begin
          collected++;
          if (collected == count_i) begin
            $display("test %0d: %0d instructions, %0d mismatches",
                     tests_o, collected, test_err);
            if (test_err != 0) begin
              failed_o++;
            end
            active = 1'b0;
            done_o = 1'b1;
          end
        end
      end

      // an issue in the redirect cycle belongs to the old stream
      if (redirect_i) begin
        exp_pc    = start_pc();
        collected = 0;
        test_err  = 0;
        started   = 1'b1;
        active    = 1'b1;
        done_o    = 1'b0;
        tests_o++;
      end
    end
  end

endmodule

// ==== verif/fetch_tb.sv ====
/*
 * fetch stage testbench
 * clock, reset, req/gnt/rvalid memory model with random delays and
 * decode back-pressure, test sequence from the cases file
 */
module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk;
  logic                  rst_n;
  fetch_pkg::addr_t      boot_addr_i;
  logic                  redirect_i;
  fetch_pkg::pc_src_e    pc_src_i;
  fetch_pkg::addr_t      jump_target_i;
  fetch_pkg::addr_t      epc_i;
  fetch_pkg::exc_cause_e exc_cause_i;
  logic                  take_i;
  logic                  instr_req_o;
  fetch_pkg::addr_t      instr_addr_o;
  logic                  instr_gnt_i;
  logic                  instr_rvalid_i;
  fetch_pkg::word_t      instr_rdata_i;
  logic                  valid_o;
  fetch_pkg::word_t      instr_o;
  fetch_pkg::addr_t      pc_o;
  fetch_pkg::word_t      instr_id_o;
  fetch_pkg::addr_t      pc_id_o;

  fetch_pkg::word_t mem [256];
  logic [1:0]       t_src [32];
  logic [31:0]      t_target [32];
  logic [31:0]      t_epc [32];
  logic [1:0]       t_cause [32];
  int               t_count [32];
  int               num_tests;
  int               cur_count;
  int               limit;
  int               cycles;
  logic             loaded;
  logic [31:0]      lfsr_q;
  logic             done;
  int               errors;
  int               failed;
  int               tests;

  fetch_top #(
    .EXC_VEC_BITS(5)
  ) dut (
    .clk(clk), .rst_n(rst_n), .boot_addr_i(boot_addr_i), .redirect_i(redirect_i),
    .pc_src_i(pc_src_i), .jump_target_i(jump_target_i), .epc_i(epc_i),
    .exc_cause_i(exc_cause_i), .take_i(take_i), .instr_req_o(instr_req_o),
    .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i), .instr_rdata_i(instr_rdata_i),
    .valid_o(valid_o), .instr_o(instr_o), .pc_o(pc_o),
    .instr_id_o(instr_id_o), .pc_id_o(pc_id_o)
  );

  fetch_checker #(
    .EXC_VEC_BITS(5)
  ) chk (
    .clk(clk), .rst_n(rst_n), .mem_i(mem), .boot_addr_i(boot_addr_i),
    .redirect_i(redirect_i), .pc_src_i(pc_src_i), .jump_target_i(jump_target_i),
    .epc_i(epc_i), .exc_cause_i(exc_cause_i), .count_i(cur_count),
    .valid_i(valid_o), .take_i(take_i), .instr_i(instr_o), .pc_i(pc_o),
    .instr_id_i(instr_id_o), .pc_id_i(pc_id_o), .done_o(done),
    .errors_o(errors), .failed_o(failed), .tests_o(tests)
  );

  // Galois LFSR, one step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic load_cases();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] d;
    int          src;
    int          cause;
    int          cnt;
    // fill words are 32-bit opcodes tagged with their index
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], 12'h5a5, i[7:0], 4'h3};
    end
    num_tests = 0;
    fd = $fopen("verif/fetch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the cases file verif/fetch_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "M %h %h", a, d) == 2) begin
          mem[a[9:2]] = d;
        end else if ($sscanf(line, "T %d %h %h %d %d", src, a, d, cause, cnt) == 5) begin
          t_src[num_tests]    = src[1:0];
          t_target[num_tests] = a;
          t_epc[num_tests]    = d;
          t_cause[num_tests]  = cause[1:0];
          t_count[num_tests]  = cnt;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // memory model and decode back-pressure
  ////////////////////////////////////////////////////////////

  initial begin
    logic             pend;
    logic [1:0]       pend_cnt;
    fetch_pkg::addr_t pend_addr;
    int               gnt_wait;
    pend      = 1'b0;
    pend_cnt  = 2'd0;
    pend_addr = '0;
    gnt_wait  = 0;
    // start on the first real clock edge
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        pend = 1'b0;
      end else begin
        if (instr_rvalid_i) begin
          pend = 1'b0;
        end
        if (instr_req_o && instr_gnt_i) begin
          pend      = 1'b1;
          pend_addr = instr_addr_o;
          pend_cnt  = 2'(take_bits(2) % 3 + 1);
          gnt_wait  = take_bits(2);
        end else if (instr_req_o && gnt_wait != 0) begin
          gnt_wait--;
        end
      end
      @(posedge clk);
      #1;
      // decode stalls on about a quarter of the cycles
      take_i         = take_bits(2) != 0;
      instr_gnt_i    = rst_n && gnt_wait == 0;
      instr_rvalid_i = 1'b0;
      if (pend) begin
        if (pend_cnt > 2'd1) begin
          pend_cnt = pend_cnt - 2'd1;
        end else begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = mem[pend_addr[9:2]];
        end
      end
    end
  end

  // cycle limit from the total instruction count
  initial begin
    cycles = 0;
    wait (loaded);
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles: the fetch stage stopped issuing", cycles);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total;
    lfsr_q         = 32'h99a4_343f;
    loaded         = 1'b0;
    rst_n          = 1'b0;
    boot_addr_i    = 32'h0000_0093;
    redirect_i     = 1'b0;
    pc_src_i       = fetch_pkg::PC_BOOT;
    jump_target_i  = '0;
    epc_i          = '0;
    exc_cause_i    = fetch_pkg::EXC_RST;
    take_i         = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    cur_count      = 0;
    load_cases();
    total = 0;
    for (int k = 0; k < num_tests; k++) begin
      total += t_count[k];
    end
    limit  = total * 12 + 200;
    loaded = 1'b1;

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int k = 0; k < num_tests; k++) begin
      @(posedge clk);
      #1;
      pc_src_i      = fetch_pkg::pc_src_e'(t_src[k]);
      jump_target_i = t_target[k];
      epc_i         = t_epc[k];
      exc_cause_i   = fetch_pkg::exc_cause_e'(t_cause[k]);
      cur_count     = t_count[k];
      redirect_i    = 1'b1;
      @(posedge clk);
      #1 redirect_i = 1'b0;
      while (!done) begin
        @(posedge clk);
      end
    end
    repeat (4) @(posedge clk);

    $display("%0d tests run, %0d failed, %0d mismatches", tests, failed, errors);
    if (errors == 0 && failed == 0 && tests == num_tests && num_tests > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/fetch_pkg.sv
verilog/fetch_if.sv
verilog/pc_select.sv
verilog/instr_mem_port.sv
verilog/if_align.sv
verilog/fetch_top.sv
verif/fetch_sva.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_tb -f sources.f -o fetch_sim \
  > build.log 2>&1 \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Something failed" sim.log \
  && { echo "simulation reported a failure, see sim.log"; exit 1; } \
  || { echo "simulation finished without failures"; exit 0; }

// ==== verif/fetch_cases.txt ====
# M <byte address> <word>          memory image, hex
# T <pc_src> <target> <epc> <cause> <count>   pc_src 0 boot 1 jump 2 exc 3 eret
M 080 11100093
M 084 22200113
M 088 33300193
M 08C 44400213
M 090 55500293
M 100 05134501
M 104 45851234
M 108 56780613
M 10C 46854605
M 110 07934705
M 114 08139abc
M 118 4885def0
M 11C 00a00893
M 120 00b00913
M 124 00c00993
T 0 0 0 0 5
T 1 100 0 0 11
T 1 10E 0 0 3
T 1 112 0 0 3
T 2 0 0 0 2
T 2 0 0 1 2
T 2 0 0 2 2
T 2 0 0 3 2
T 3 0 106 0 3
T 1 11C 0 0 2
T 1 102 0 0 6
